// ==== common/fpu_pkg.sv ====
package fpu_pkg;

  // packed operand widths
  localparam int DATA_W   = 64;
  localparam int SINGLE_W = 32;
  localparam int FLAG_W   = 11;
  localparam int IDX_W    = 4;
  localparam int TAG_W    = 9;

  // forwarding buses with lanes 0 and 1 first
  localparam int NUM_FWD = 6;

  // enable field of fpcsr
  localparam int FLAG_EN_LSB = 11;

  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [SINGLE_W-1:0] single_t;
  typedef logic [FLAG_W-1:0]   flags_t;
  typedef logic [IDX_W-1:0]    excpt_idx_t;
  typedef logic [TAG_W-1:0]    rob_tag_t;
  typedef logic [NUM_FWD-1:0]  fwd_sel_t;

  // low two bits pick the logic function or the permute kind
  typedef enum logic [2:0] {
    OP_AND   = 3'd0,
    OP_OR    = 3'd1,
    OP_XOR   = 3'd2,
    OP_ANDN  = 3'd3,
    OP_SWAP  = 3'd4,
    OP_DUP   = 3'd5,
    OP_MERGE = 3'd6,
    OP_MOVB  = 3'd7
  } fpu_op_e;

  // logic unit selects
  localparam logic [1:0] LSEL_AND  = 2'd0;
  localparam logic [1:0] LSEL_OR   = 2'd1;
  localparam logic [1:0] LSEL_XOR  = 2'd2;
  localparam logic [1:0] LSEL_ANDN = 2'd3;

  // permute control bits
  localparam int PERM_SWP = 2;
  localparam int PERM_DUP = 1;
  localparam int PERM_CPA = 0;

endpackage

// ==== common/fpu_issue_if.sv ====
`timescale 1ns/10ps

interface fpu_issue_if;

  logic              en;
  fpu_pkg::fpu_op_e  op;
  fpu_pkg::data_t    a;
  fpu_pkg::data_t    b;
  fpu_pkg::fwd_sel_t a_fwd_now;
  fpu_pkg::fwd_sel_t a_fwd_old;
  fpu_pkg::fwd_sel_t b_fwd_now;
  fpu_pkg::fwd_sel_t b_fwd_old;
  fpu_pkg::rob_tag_t tag;
  fpu_pkg::flags_t   raise;

  modport issue (
    output en, op, a, b,
    output a_fwd_now, a_fwd_old, b_fwd_now, b_fwd_old,
    output tag, raise
  );

  modport lane (
    input en, op, a, b,
    input a_fwd_now, a_fwd_old, b_fwd_now, b_fwd_old,
    input tag, raise
  );

endinterface

// ==== hdl/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward #(
  parameter int num_fwd = fpu_pkg::NUM_FWD
) (
  input  logic              clk,
  input  logic              rst,
  input  fpu_pkg::data_t    port_val,
  input  fpu_pkg::fwd_sel_t fwd_now,
  input  fpu_pkg::fwd_sel_t fwd_old,
  input  fpu_pkg::data_t    fwd_bus [num_fwd],
  output fpu_pkg::data_t    operand
);

  // bus values from the previous edge
  fpu_pkg::data_t bus_old [num_fwd];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_fwd; i++) begin
        bus_old[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_fwd; i++) begin
        bus_old[i] <= fwd_bus[i];
      end
    end
  end

  // now beats old, old beats the port
  always_comb begin
    operand = port_val;
    for (int i = 0; i < num_fwd; i++) begin
      if (fwd_old[i]) begin
        operand = bus_old[i];
      end
    end
    for (int i = 0; i < num_fwd; i++) begin
      if (fwd_now[i]) begin
        operand = fwd_bus[i];
      end
    end
  end

endmodule

// ==== lane/simd_exec.sv ====
`timescale 1ns/10ps

module simd_exec (
  input  logic           clk,
  input  logic           rst,
  input  logic           valid,
  input  logic           logic_en,
  input  logic [1:0]     logic_sel,
  input  logic [2:0]     perm_ctrl,
  input  fpu_pkg::data_t a,
  input  fpu_pkg::data_t b,
  output fpu_pkg::data_t res,
  output logic           res_valid
);

  fpu_pkg::single_t a_hi;
  fpu_pkg::single_t a_lo;
  fpu_pkg::single_t b_lo;
  fpu_pkg::data_t   logic_res;
  fpu_pkg::data_t   perm_res;

  assign a_hi = a[63:32];
  assign a_lo = a[31:0];
  assign b_lo = b[31:0];

  always_comb begin
    case (logic_sel)
      fpu_pkg::LSEL_AND: logic_res = a & b;
      fpu_pkg::LSEL_OR:  logic_res = a | b;
      fpu_pkg::LSEL_XOR: logic_res = a ^ b;
      default:           logic_res = a & ~b;
    endcase
  end

  // swap has priority in single placement
  always_comb begin
    if (perm_ctrl[fpu_pkg::PERM_SWP]) begin
      perm_res = {a_lo, a_hi};
    end else if (perm_ctrl[fpu_pkg::PERM_DUP]) begin
      perm_res = {b_lo, b_lo};
    end else if (perm_ctrl[fpu_pkg::PERM_CPA]) begin
      perm_res = {a_hi, b_lo};
    end else begin
      perm_res = b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= valid;
      if (valid) begin
        res <= logic_en ? logic_res : perm_res;
      end
    end
  end

endmodule

// ==== lane/fp_excpt.sv ====
`timescale 1ns/10ps

module fp_excpt (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid,
  input  fpu_pkg::rob_tag_t   tag,
  input  fpu_pkg::flags_t     raise,
  input  fpu_pkg::flags_t     flag_en,
  output fpu_pkg::rob_tag_t   ret_tag,
  output logic                ret_excpt,
  output fpu_pkg::excpt_idx_t ret_idx,
  output logic                ret_en
);

  fpu_pkg::flags_t     masked;
  fpu_pkg::excpt_idx_t low_idx;

  // lowest enabled flag wins
  always_comb begin
    masked  = raise & flag_en;
    low_idx = '0;
    for (int i = fpu_pkg::FLAG_W - 1; i >= 0; i--) begin
      if (masked[i]) begin
        low_idx = fpu_pkg::excpt_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_tag   <= '0;
      ret_excpt <= 1'b0;
      ret_idx   <= '0;
      ret_en    <= 1'b0;
    end else begin
      ret_en <= valid;
      if (valid) begin
        ret_tag   <= tag;
        ret_excpt <= |masked;
        ret_idx   <= low_idx;
      end
    end
  end

endmodule

// ==== lane/fpu_lane.sv ====
`timescale 1ns/10ps

module fpu_lane #(
  parameter int num_fwd = fpu_pkg::NUM_FWD
) (
  input  logic                clk,
  input  logic                rst,
  fpu_issue_if.lane           iss,
  input  fpu_pkg::data_t      fwd_bus [num_fwd],
  input  fpu_pkg::flags_t     flag_en,
  output fpu_pkg::data_t      res,
  output logic                res_valid,
  output fpu_pkg::rob_tag_t   ret_tag,
  output logic                ret_excpt,
  output fpu_pkg::excpt_idx_t ret_idx,
  output logic                ret_en
);

  fpu_pkg::data_t    opa;
  fpu_pkg::data_t    opb;
  logic              logic_en_d;
  logic [1:0]        logic_sel_d;
  logic [2:0]        perm_ctrl_d;

  // stage one
  logic              valid_q;
  logic              logic_en_q;
  logic [1:0]        logic_sel_q;
  logic [2:0]        perm_ctrl_q;
  fpu_pkg::data_t    a_q;
  fpu_pkg::data_t    b_q;
  fpu_pkg::rob_tag_t tag_q;
  fpu_pkg::flags_t   raise_q;

  operand_forward #(.num_fwd(num_fwd)) opa_fwd (
    .clk      (clk),
    .rst      (rst),
    .port_val (iss.a),
    .fwd_now  (iss.a_fwd_now),
    .fwd_old  (iss.a_fwd_old),
    .fwd_bus  (fwd_bus),
    .operand  (opa)
  );

  operand_forward #(.num_fwd(num_fwd)) opb_fwd (
    .clk      (clk),
    .rst      (rst),
    .port_val (iss.b),
    .fwd_now  (iss.b_fwd_now),
    .fwd_old  (iss.b_fwd_old),
    .fwd_bus  (fwd_bus),
    .operand  (opb)
  );

  // logic path vs permuter split
  always_comb begin
    logic_en_d  = 1'b0;
    logic_sel_d = fpu_pkg::LSEL_AND;
    perm_ctrl_d = 3'b000;
    case (iss.op)
      fpu_pkg::OP_AND: begin
        logic_en_d  = 1'b1;
        logic_sel_d = fpu_pkg::LSEL_AND;
      end
      fpu_pkg::OP_OR: begin
        logic_en_d  = 1'b1;
        logic_sel_d = fpu_pkg::LSEL_OR;
      end
      fpu_pkg::OP_XOR: begin
        logic_en_d  = 1'b1;
        logic_sel_d = fpu_pkg::LSEL_XOR;
      end
      fpu_pkg::OP_ANDN: begin
        logic_en_d  = 1'b1;
        logic_sel_d = fpu_pkg::LSEL_ANDN;
      end
      fpu_pkg::OP_SWAP:  perm_ctrl_d[fpu_pkg::PERM_SWP] = 1'b1;
      fpu_pkg::OP_DUP:   perm_ctrl_d[fpu_pkg::PERM_DUP] = 1'b1;
      fpu_pkg::OP_MERGE: perm_ctrl_d[fpu_pkg::PERM_CPA] = 1'b1;
      default:           perm_ctrl_d = 3'b000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q     <= 1'b0;
      logic_en_q  <= 1'b0;
      logic_sel_q <= 2'b00;
      perm_ctrl_q <= 3'b000;
    end else begin
      valid_q <= iss.en;
      if (iss.en) begin
        logic_en_q  <= logic_en_d;
        logic_sel_q <= logic_sel_d;
        perm_ctrl_q <= perm_ctrl_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (iss.en) begin
      a_q     <= opa;
      b_q     <= opb;
      tag_q   <= iss.tag;
      raise_q <= iss.raise;
    end
  end

  simd_exec exec (
    .clk       (clk),
    .rst       (rst),
    .valid     (valid_q),
    .logic_en  (logic_en_q),
    .logic_sel (logic_sel_q),
    .perm_ctrl (perm_ctrl_q),
    .a         (a_q),
    .b         (b_q),
    .res       (res),
    .res_valid (res_valid)
  );

  fp_excpt excpt (
    .clk       (clk),
    .rst       (rst),
    .valid     (valid_q),
    .tag       (tag_q),
    .raise     (raise_q),
    .flag_en   (flag_en),
    .ret_tag   (ret_tag),
    .ret_excpt (ret_excpt),
    .ret_idx   (ret_idx),
    .ret_en    (ret_en)
  );

endmodule

// ==== hdl/fpu_cluster.sv ====
`timescale 1ns/10ps

module fpu_cluster #(
  parameter int num_fwd = fpu_pkg::NUM_FWD
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         fpcsr,
  input  logic                u0_en,
  input  fpu_pkg::fpu_op_e    u0_op,
  input  fpu_pkg::data_t      u0_a,
  input  fpu_pkg::data_t      u0_b,
  input  fpu_pkg::fwd_sel_t   u0_a_fwd_now,
  input  fpu_pkg::fwd_sel_t   u0_a_fwd_old,
  input  fpu_pkg::fwd_sel_t   u0_b_fwd_now,
  input  fpu_pkg::fwd_sel_t   u0_b_fwd_old,
  input  fpu_pkg::rob_tag_t   u0_tag,
  input  fpu_pkg::flags_t     u0_raise,
  output fpu_pkg::data_t      u0_res,
  output logic                u0_res_valid,
  output fpu_pkg::rob_tag_t   u0_ret_tag,
  output logic                u0_ret_excpt,
  output fpu_pkg::excpt_idx_t u0_ret_idx,
  output logic                u0_ret_en,
  input  logic                u1_en,
  input  fpu_pkg::fpu_op_e    u1_op,
  input  fpu_pkg::data_t      u1_a,
  input  fpu_pkg::data_t      u1_b,
  input  fpu_pkg::fwd_sel_t   u1_a_fwd_now,
  input  fpu_pkg::fwd_sel_t   u1_a_fwd_old,
  input  fpu_pkg::fwd_sel_t   u1_b_fwd_now,
  input  fpu_pkg::fwd_sel_t   u1_b_fwd_old,
  input  fpu_pkg::rob_tag_t   u1_tag,
  input  fpu_pkg::flags_t     u1_raise,
  output fpu_pkg::data_t      u1_res,
  output logic                u1_res_valid,
  output fpu_pkg::rob_tag_t   u1_ret_tag,
  output logic                u1_ret_excpt,
  output fpu_pkg::excpt_idx_t u1_ret_idx,
  output logic                u1_ret_en,
  input  fpu_pkg::data_t      ext_fwd [num_fwd-2]
);

  fpu_pkg::data_t  fwd_bus [num_fwd];
  fpu_pkg::flags_t flag_en;

  fpu_issue_if iss0 ();
  fpu_issue_if iss1 ();

  assign flag_en = fpcsr[fpu_pkg::FLAG_EN_LSB +: fpu_pkg::FLAG_W];

  // lane results own buses 0 and 1
  assign fwd_bus[0] = u0_res;
  assign fwd_bus[1] = u1_res;

  for (genvar i = 0; i < num_fwd - 2; i++) begin : g_ext
    assign fwd_bus[i+2] = ext_fwd[i];
  end

  assign iss0.en        = u0_en;
  assign iss0.op        = u0_op;
  assign iss0.a         = u0_a;
  assign iss0.b         = u0_b;
  assign iss0.a_fwd_now = u0_a_fwd_now;
  assign iss0.a_fwd_old = u0_a_fwd_old;
  assign iss0.b_fwd_now = u0_b_fwd_now;
  assign iss0.b_fwd_old = u0_b_fwd_old;
  assign iss0.tag       = u0_tag;
  assign iss0.raise     = u0_raise;

  assign iss1.en        = u1_en;
  assign iss1.op        = u1_op;
  assign iss1.a         = u1_a;
  assign iss1.b         = u1_b;
  assign iss1.a_fwd_now = u1_a_fwd_now;
  assign iss1.a_fwd_old = u1_a_fwd_old;
  assign iss1.b_fwd_now = u1_b_fwd_now;
  assign iss1.b_fwd_old = u1_b_fwd_old;
  assign iss1.tag       = u1_tag;
  assign iss1.raise     = u1_raise;

  fpu_lane #(.num_fwd(num_fwd)) lane0 (
    .clk       (clk),
    .rst       (rst),
    .iss       (iss0.lane),
    .fwd_bus   (fwd_bus),
    .flag_en   (flag_en),
    .res       (u0_res),
    .res_valid (u0_res_valid),
    .ret_tag   (u0_ret_tag),
    .ret_excpt (u0_ret_excpt),
    .ret_idx   (u0_ret_idx),
    .ret_en    (u0_ret_en)
  );

  fpu_lane #(.num_fwd(num_fwd)) lane1 (
    .clk       (clk),
    .rst       (rst),
    .iss       (iss1.lane),
    .fwd_bus   (fwd_bus),
    .flag_en   (flag_en),
    .res       (u1_res),
    .res_valid (u1_res_valid),
    .ret_tag   (u1_ret_tag),
    .ret_excpt (u1_ret_excpt),
    .ret_idx   (u1_ret_idx),
    .ret_en    (u1_ret_en)
  );

endmodule

// ==== tests/fpu_cluster_asserts.sv ====
`timescale 1ns/10ps

module fpu_cluster_asserts (
  input logic              clk,
  input logic              rst,
  input logic              u0_res_valid,
  input logic              u0_ret_en,
  input logic              u1_res_valid,
  input logic              u1_ret_en,
  input fpu_pkg::fwd_sel_t u0_a_fwd_now,
  input fpu_pkg::fwd_sel_t u0_a_fwd_old,
  input fpu_pkg::fwd_sel_t u0_b_fwd_now,
  input fpu_pkg::fwd_sel_t u0_b_fwd_old,
  input fpu_pkg::fwd_sel_t u1_a_fwd_now,
  input fpu_pkg::fwd_sel_t u1_a_fwd_old,
  input fpu_pkg::fwd_sel_t u1_b_fwd_now,
  input fpu_pkg::fwd_sel_t u1_b_fwd_old
);

  int fail_count = 0;

  function automatic logic sel_legal(input fpu_pkg::fwd_sel_t now,
                                     input fpu_pkg::fwd_sel_t old);
    return ($countones(now) + $countones(old)) <= 1;
  endfunction

  // retire record leaves with the result
  ret_with_res: assert property (@(posedge clk) disable iff (rst)
    (u0_ret_en == u0_res_valid) && (u1_ret_en == u1_res_valid))
    else begin
      fail_count++;
      $error("ret_en differs from res_valid");
    end

  sel_onehot: assert property (@(posedge clk) disable iff (rst)
    sel_legal(u0_a_fwd_now, u0_a_fwd_old) && sel_legal(u0_b_fwd_now, u0_b_fwd_old) &&
    sel_legal(u1_a_fwd_now, u1_a_fwd_old) && sel_legal(u1_b_fwd_now, u1_b_fwd_old))
    else begin
      fail_count++;
      $error("more than one forwarding select set for an operand");
    end

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !u0_res_valid && !u0_ret_en && !u1_res_valid && !u1_ret_en)
    else begin
      fail_count++;
      $error("valid outputs high right after reset");
    end

endmodule

bind fpu_cluster fpu_cluster_asserts asserts0 (
  .clk          (clk),
  .rst          (rst),
  .u0_res_valid (u0_res_valid),
  .u0_ret_en    (u0_ret_en),
  .u1_res_valid (u1_res_valid),
  .u1_ret_en    (u1_ret_en),
  .u0_a_fwd_now (u0_a_fwd_now),
  .u0_a_fwd_old (u0_a_fwd_old),
  .u0_b_fwd_now (u0_b_fwd_now),
  .u0_b_fwd_old (u0_b_fwd_old),
  .u1_a_fwd_now (u1_a_fwd_now),
  .u1_a_fwd_old (u1_a_fwd_old),
  .u1_b_fwd_now (u1_b_fwd_now),
  .u1_b_fwd_old (u1_b_fwd_old)
);

// ==== tests/tb_fpu_cluster.sv ====
`timescale 1ns/10ps

module tb_fpu_cluster;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_N       = 8;
  localparam int RUN_N        = 200;
  localparam int MIXED_N      = 300;
  localparam int TEST_CYCLES  = 2 * IDLE_N + 4 * RUN_N + MIXED_N;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;
  localparam int NF           = fpu_pkg::NUM_FWD;

  logic                clk;
  logic                rst;
  logic [31:0]         fpcsr;
  logic                en_d [2];
  fpu_pkg::fpu_op_e    op_d [2];
  fpu_pkg::data_t      a_d [2];
  fpu_pkg::data_t      b_d [2];
  fpu_pkg::fwd_sel_t   a_now [2];
  fpu_pkg::fwd_sel_t   a_old [2];
  fpu_pkg::fwd_sel_t   b_now [2];
  fpu_pkg::fwd_sel_t   b_old [2];
  fpu_pkg::rob_tag_t   tag_d [2];
  fpu_pkg::flags_t     raise_d [2];
  fpu_pkg::data_t      ext_fwd [NF-2];
  fpu_pkg::data_t      res_o [2];
  logic                valid_o [2];
  fpu_pkg::rob_tag_t   tag_o [2];
  logic                excpt_o [2];
  fpu_pkg::excpt_idx_t idx_o [2];
  logic                ret_en_o [2];

  // model of what each lane shows and holds in stage one
  fpu_pkg::data_t      m_res [2];
  logic                m_valid [2];
  fpu_pkg::rob_tag_t   m_tag [2];
  logic                m_excpt [2];
  fpu_pkg::excpt_idx_t m_idx [2];
  logic                s1_valid [2];
  fpu_pkg::data_t      s1_res [2];
  fpu_pkg::rob_tag_t   s1_tag [2];
  fpu_pkg::flags_t     s1_raise [2];
  fpu_pkg::data_t      bus_cur [NF];
  fpu_pkg::data_t      bus_old [NF];
  logic [31:0]         lfsr;

  fpu_cluster #(.num_fwd(NF)) dut0 (
    .clk          (clk),
    .rst          (rst),
    .fpcsr        (fpcsr),
    .u0_en        (en_d[0]),
    .u0_op        (op_d[0]),
    .u0_a         (a_d[0]),
    .u0_b         (b_d[0]),
    .u0_a_fwd_now (a_now[0]),
    .u0_a_fwd_old (a_old[0]),
    .u0_b_fwd_now (b_now[0]),
    .u0_b_fwd_old (b_old[0]),
    .u0_tag       (tag_d[0]),
    .u0_raise     (raise_d[0]),
    .u0_res       (res_o[0]),
    .u0_res_valid (valid_o[0]),
    .u0_ret_tag   (tag_o[0]),
    .u0_ret_excpt (excpt_o[0]),
    .u0_ret_idx   (idx_o[0]),
    .u0_ret_en    (ret_en_o[0]),
    .u1_en        (en_d[1]),
    .u1_op        (op_d[1]),
    .u1_a         (a_d[1]),
    .u1_b         (b_d[1]),
    .u1_a_fwd_now (a_now[1]),
    .u1_a_fwd_old (a_old[1]),
    .u1_b_fwd_now (b_now[1]),
    .u1_b_fwd_old (b_old[1]),
    .u1_tag       (tag_d[1]),
    .u1_raise     (raise_d[1]),
    .u1_res       (res_o[1]),
    .u1_res_valid (valid_o[1]),
    .u1_ret_tag   (tag_o[1]),
    .u1_ret_excpt (excpt_o[1]),
    .u1_ret_idx   (idx_o[1]),
    .u1_ret_en    (ret_en_o[1]),
    .ext_fwd      (ext_fwd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hb4bcd35c) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic fpu_pkg::fwd_sel_t bus_select();
    int idx;
    idx = int'(rand_bits(3)) % NF;
    return fpu_pkg::fwd_sel_t'(1) << idx;
  endfunction

  function automatic fpu_pkg::data_t apply_op(input fpu_pkg::fpu_op_e op,
                                              input fpu_pkg::data_t a,
                                              input fpu_pkg::data_t b);
    case (op)
      fpu_pkg::OP_AND:   return a & b;
      fpu_pkg::OP_OR:    return a | b;
      fpu_pkg::OP_XOR:   return a ^ b;
      fpu_pkg::OP_ANDN:  return a & ~b;
      fpu_pkg::OP_SWAP:  return {a[31:0], a[63:32]};
      fpu_pkg::OP_DUP:   return {b[31:0], b[31:0]};
      fpu_pkg::OP_MERGE: return {a[63:32], b[31:0]};
      default:           return b;
    endcase
  endfunction

  function automatic fpu_pkg::excpt_idx_t lowest_flag(input fpu_pkg::flags_t m);
    fpu_pkg::excpt_idx_t idx;
    logic                found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < fpu_pkg::FLAG_W; i++) begin
      if (m[i] && !found) begin
        idx = fpu_pkg::excpt_idx_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // at most one bit set across now and old
  function automatic fpu_pkg::data_t resolve_operand(input fpu_pkg::data_t port,
                                                     input fpu_pkg::fwd_sel_t now,
                                                     input fpu_pkg::fwd_sel_t old);
    fpu_pkg::data_t v;
    v = port;
    for (int i = 0; i < NF; i++) begin
      if (now[i]) begin
        v = bus_cur[i];
      end else if (old[i]) begin
        v = bus_old[i];
      end
    end
    return v;
  endfunction

  // one rising edge of the reference model
  task automatic model_step();
    fpu_pkg::flags_t masked;
    fpu_pkg::data_t  opa;
    fpu_pkg::data_t  opb;
    bus_cur[0] = m_res[0];
    bus_cur[1] = m_res[1];
    for (int i = 2; i < NF; i++) begin
      bus_cur[i] = ext_fwd[i-2];
    end
    for (int l = 0; l < 2; l++) begin
      m_valid[l] = s1_valid[l];
      if (s1_valid[l]) begin
        masked     = s1_raise[l] & fpcsr[fpu_pkg::FLAG_EN_LSB +: fpu_pkg::FLAG_W];
        m_res[l]   = s1_res[l];
        m_tag[l]   = s1_tag[l];
        m_excpt[l] = |masked;
        m_idx[l]   = lowest_flag(masked);
      end
      s1_valid[l] = en_d[l];
      if (en_d[l]) begin
        opa         = resolve_operand(a_d[l], a_now[l], a_old[l]);
        opb         = resolve_operand(b_d[l], b_now[l], b_old[l]);
        s1_res[l]   = apply_op(op_d[l], opa, opb);
        s1_tag[l]   = tag_d[l];
        s1_raise[l] = raise_d[l];
      end
    end
    for (int i = 0; i < NF; i++) begin
      bus_old[i] = bus_cur[i];
    end
  endtask

  // mode 3 forwards now, mode 4 old, mode 5 picks at random
  task automatic choose_selects(input int mode, output fpu_pkg::fwd_sel_t now,
                                output fpu_pkg::fwd_sel_t old);
    int kind;
    kind = (mode == 3) ? 1 : (mode == 4) ? 2 : 0;
    if (mode == 5) begin
      kind = int'(rand_bits(2));
    end
    now = (kind == 1) ? bus_select() : '0;
    old = (kind == 2) ? bus_select() : '0;
  endtask

  task automatic drive_lanes(input int mode);
    logic [63:0]       r;
    fpu_pkg::fwd_sel_t now;
    fpu_pkg::fwd_sel_t old;
    for (int l = 0; l < 2; l++) begin
      r = rand_bits(4);
      if (mode == 1) begin
        r[2] = 1'b0;
      end
      if (mode == 2) begin
        r[2] = 1'b1;
      end
      en_d[l]    <= (mode == 5) ? r[3] : (mode != 0);
      op_d[l]    <= fpu_pkg::fpu_op_e'(r[2:0]);
      a_d[l]     <= rand_bits(64);
      b_d[l]     <= rand_bits(64);
      tag_d[l]   <= fpu_pkg::rob_tag_t'(rand_bits(9));
      raise_d[l] <= fpu_pkg::flags_t'(rand_bits(11));
      choose_selects(mode, now, old);
      a_now[l] <= now;
      a_old[l] <= old;
      choose_selects(mode, now, old);
      b_now[l] <= now;
      b_old[l] <= old;
    end
    for (int i = 0; i < NF - 2; i++) begin
      ext_fwd[i] <= rand_bits(64);
    end
    fpcsr <= 32'(rand_bits(32));
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic check_outputs(input string name);
    for (int l = 0; l < 2; l++) begin
      compare($sformatf("%s lane%0d res", name, l), m_res[l], res_o[l]);
      compare($sformatf("%s lane%0d res_valid", name, l), 64'(m_valid[l]), 64'(valid_o[l]));
      compare($sformatf("%s lane%0d ret_tag", name, l), 64'(m_tag[l]), 64'(tag_o[l]));
      compare($sformatf("%s lane%0d ret_excpt", name, l), 64'(m_excpt[l]), 64'(excpt_o[l]));
      compare($sformatf("%s lane%0d ret_idx", name, l), 64'(m_idx[l]), 64'(idx_o[l]));
      compare($sformatf("%s lane%0d ret_en", name, l), 64'(m_valid[l]), 64'(ret_en_o[l]));
    end
  endtask

  // outputs are sampled at the falling edge
  task automatic run_test(input string name, input int mode, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      model_step();
      drive_lanes(mode);
      @(negedge clk);
      check_outputs(name);
    end
  endtask

  initial begin
    lfsr = 32'ha82a;
    rst <= 1'b1;
    fpcsr <= '0;
    for (int l = 0; l < 2; l++) begin
      en_d[l]     <= 1'b0;
      op_d[l]     <= fpu_pkg::OP_AND;
      a_d[l]      <= '0;
      b_d[l]      <= '0;
      a_now[l]    <= '0;
      a_old[l]    <= '0;
      b_now[l]    <= '0;
      b_old[l]    <= '0;
      tag_d[l]    <= '0;
      raise_d[l]  <= '0;
      m_res[l]    = '0;
      m_valid[l]  = 1'b0;
      m_tag[l]    = '0;
      m_excpt[l]  = 1'b0;
      m_idx[l]    = '0;
      s1_valid[l] = 1'b0;
      s1_res[l]   = '0;
      s1_tag[l]   = '0;
      s1_raise[l] = '0;
    end
    for (int i = 0; i < NF; i++) begin
      bus_cur[i] = '0;
      bus_old[i] = '0;
    end
    for (int i = 0; i < NF - 2; i++) begin
      ext_fwd[i] <= '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_test("idle_after_reset", 0, IDLE_N);
    run_test("logic_ops", 1, RUN_N);
    run_test("permute_ops", 2, RUN_N);
    run_test("forward_now", 3, RUN_N);
    run_test("forward_old", 4, RUN_N);
    run_test("retire_excpt", 5, MIXED_N);
    run_test("idle_drain", 0, IDLE_N);
    if (dut0.asserts0.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("%0d assertion failures in the DUT", dut0.asserts0.fail_count);
      $display("Some tests failed");
      $fatal(1, "assertions failed in the DUT");
    end
  end

endmodule

// ==== src.f ====
common/fpu_pkg.sv
common/fpu_issue_if.sv
hdl/operand_forward.sv
lane/simd_exec.sv
lane/fp_excpt.sv
lane/fpu_lane.sv
hdl/fpu_cluster.sv
tests/fpu_cluster_asserts.sv
tests/tb_fpu_cluster.sv

// ==== Makefile ====
SIM       = verilator
TOP       = tb_fpu_cluster
FILELIST  = src.f
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
RUNFLAGS  = +verilator+error+limit+100
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
